// ==== hw/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural register file size
`define RN_ARCH_REGS 32

// Physical registers, eight left over for renaming
`define RN_PHYS_REGS 40

// In-flight instruction window
`define RN_ROB_DEPTH 16

`endif

// ==== hw/rename_types_pkg.sv ====
`default_nettype none

`include "rename_defines.svh"

package rename_types_pkg;

    // Register tags
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_tag_t;
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_tag_t;

    // Reorder buffer slot and occupancy
    typedef logic [$clog2(`RN_ROB_DEPTH)-1:0]   rob_idx_t;
    typedef logic [$clog2(`RN_ROB_DEPTH+1)-1:0] rob_cnt_t;

    // Free list never holds more than the spare tags
    typedef logic [$clog2(`RN_PHYS_REGS-`RN_ARCH_REGS+1)-1:0] fl_cnt_t;

endpackage

`default_nettype wire

// ==== hw/rename_pkt_pkg.sv ====
`default_nettype none

package rename_pkt_pkg;
    import rename_types_pkg::*;

    // One decoded instruction from the front end
    typedef struct packed {
        logic      valid;
        arch_tag_t rd;
        arch_tag_t rs1;
        arch_tag_t rs2;
    } dispatch_req_t;

    // Renamed operands and allocation, same cycle as dispatch
    typedef struct packed {
        phys_tag_t rs1_phys;
        logic      rs1_ready;
        phys_tag_t rs2_phys;
        logic      rs2_ready;
        phys_tag_t rd_new_phys;
        phys_tag_t rd_old_phys;
        rob_idx_t  rob_idx;
    } rename_rsp_t;

    // Completion pulse by buffer slot
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } wb_t;

    // In-order retirement of the oldest entry
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        logic      rd_wen;
        arch_tag_t rd_arch;
        phys_tag_t new_phys;
        phys_tag_t old_phys;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/dispatch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire rename_pkt_pkg::dispatch_req_t disp_i,
    input  wire logic                          free_empty_i,
    input  wire logic                          rob_full_i,
    output logic                               disp_ready_o,
    output logic                               alloc_o,
    output logic                               rd_write_o
);
    import rename_types_pkg::*;

    // x0 is never renamed
    localparam arch_tag_t ZERO_REG = '0;

    logic rd_nonzero;

    assign rd_nonzero = (disp_i.rd != ZERO_REG);

    // Needs a slot, and a tag only for a real destination
    assign disp_ready_o = !rob_full_i && !(free_empty_i && rd_nonzero);

    // Transfer on valid and ready
    assign alloc_o    = disp_i.valid && disp_ready_o;
    assign rd_write_o = alloc_o && rd_nonzero;

    // Stalled request is held by the front end
    a_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
        (disp_i.valid && !disp_ready_o) |=> $stable(disp_i))
        else $error("dispatch_ctrl: request changed while stalled");

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire rename_types_pkg::arch_tag_t rs1_i,
    input  wire rename_types_pkg::arch_tag_t rs2_i,
    input  wire rename_types_pkg::arch_tag_t rd_i,
    input  wire logic                        rd_write_i,
    input  wire rename_types_pkg::phys_tag_t rd_new_phys_i,
    output rename_types_pkg::phys_tag_t      rs1_phys_o,
    output rename_types_pkg::phys_tag_t      rs2_phys_o,
    output rename_types_pkg::phys_tag_t      rd_old_phys_o,
    output logic                             rs1_ready_o,
    output logic                             rs2_ready_o,
    input  wire logic                        set_ready_i,
    input  wire rename_types_pkg::phys_tag_t set_ready_tag_i
);
    import rename_types_pkg::*;

    // Speculative arch to phys mapping
    phys_tag_t                map_q [`RN_ARCH_REGS];
    // Value-ready flag per physical register
    logic [`RN_PHYS_REGS-1:0] ready_q;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // Old mapping, this cycle's rename lands at the edge
    assign rs1_phys_o    = map_q[rs1_i];
    assign rs2_phys_o    = map_q[rs2_i];
    assign rd_old_phys_o = map_q[rd_i];

    // Same-cycle writeback counts as ready
    assign rs1_ready_o = ready_q[rs1_phys_o]
                       | (set_ready_i && (set_ready_tag_i == rs1_phys_o));
    assign rs2_ready_o = ready_q[rs2_phys_o]
                       | (set_ready_i && (set_ready_tag_i == rs2_phys_o));

    //////////////////////////////
    // Update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything ready
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
            ready_q <= '1;
        end else begin
            // Wakeup from completion
            if (set_ready_i) begin
                ready_q[set_ready_tag_i] <= 1'b1;
            end
            // New producer, value pending
            if (rd_write_i) begin
                map_q[rd_i]            <= rd_new_phys_i;
                ready_q[rd_new_phys_i] <= 1'b0;
            end
        end
    end

    // x0 stays hardwired to phys 0
    a_no_r0_rename: assert property (@(posedge clock) disable iff (reset)
        rd_write_i |-> (rd_i != '0))
        else $error("map_table: rename of register 0");

endmodule

`default_nettype wire

// ==== hw/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        pop_i,
    output rename_types_pkg::phys_tag_t      head_tag_o,
    output logic                             empty_o,
    input  wire logic                        push_i,
    input  wire rename_types_pkg::phys_tag_t push_tag_i
);
    import rename_types_pkg::*;

    // Spare tags beyond the architectural set
    localparam int FL_DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);

    typedef logic [PTR_W-1:0] fl_ptr_t;

    phys_tag_t slot_q [FL_DEPTH];
    fl_ptr_t   head_q;
    fl_ptr_t   tail_q;
    fl_cnt_t   count_q;

    // Wrap at depth, need not be a power of two
    function automatic fl_ptr_t ptr_inc(input fl_ptr_t ptr);
        return (ptr == fl_ptr_t'(FL_DEPTH - 1)) ? '0 : fl_ptr_t'(ptr + 1'b1);
    endfunction

    // Next tag to hand out, no bypass from push
    assign head_tag_o = slot_q[head_q];
    assign empty_o    = (count_q == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // Starts full with the spare tags in order
            for (int i = 0; i < FL_DEPTH; i++) begin
                slot_q[i] <= phys_tag_t'(`RN_ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= fl_cnt_t'(FL_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= ptr_inc(head_q);
            end
            // Retired old tag
            if (push_i) begin
                slot_q[tail_q] <= push_tag_i;
                tail_q         <= ptr_inc(tail_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Dispatch must stall on an empty list
    a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
        pop_i |-> !empty_o)
        else $error("free_list: pop while empty");

    // More tags returned than were handed out
    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        push_i |-> (count_q != fl_cnt_t'(FL_DEPTH)))
        else $error("free_list: push while full");

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module reorder_buffer (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        alloc_i,
    input  wire logic                        rd_wen_i,
    input  wire rename_types_pkg::arch_tag_t rd_arch_i,
    input  wire rename_types_pkg::phys_tag_t new_phys_i,
    input  wire rename_types_pkg::phys_tag_t old_phys_i,
    output rename_types_pkg::rob_idx_t       tail_idx_o,
    output logic                             full_o,
    input  wire rename_pkt_pkg::wb_t         wb_i,
    output logic                             set_ready_o,
    output rename_types_pkg::phys_tag_t      set_ready_tag_o,
    output rename_pkt_pkg::commit_t          commit_o,
    output logic                             free_push_o,
    output rename_types_pkg::phys_tag_t      free_tag_o
);
    import rename_types_pkg::*;

    localparam int ROB_DEPTH = `RN_ROB_DEPTH;

    // Per-instruction bookkeeping
    typedef struct packed {
        logic      rd_wen;
        arch_tag_t arch;
        phys_tag_t new_phys;
        phys_tag_t old_phys;
        logic      done;
    } rob_entry_t;

    rob_entry_t entry_q [ROB_DEPTH];
    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    rob_cnt_t   count_q;

    rob_entry_t head_entry;
    rob_entry_t wb_entry;
    logic       commit_fire;
    // Distance of writeback slot from head
    rob_idx_t   wb_offset;

    assign head_entry = entry_q[head_q];
    assign wb_entry   = entry_q[wb_i.rob_idx];
    assign wb_offset  = wb_i.rob_idx - head_q;

    //////////////////////////////
    // Dispatch side
    //////////////////////////////

    assign tail_idx_o = tail_q;
    assign full_o     = (count_q == rob_cnt_t'(ROB_DEPTH));

    // Wake consumers, only for real destinations
    assign set_ready_o     = wb_i.valid && wb_entry.rd_wen;
    assign set_ready_tag_o = wb_entry.new_phys;

    //////////////////////////////
    // Commit
    //////////////////////////////

    // Oldest entry retires once done
    assign commit_fire = (count_q != '0) && head_entry.done;

    always_comb begin
        commit_o.valid    = commit_fire;
        commit_o.rob_idx  = head_q;
        commit_o.rd_wen   = head_entry.rd_wen;
        commit_o.rd_arch  = head_entry.arch;
        commit_o.new_phys = head_entry.new_phys;
        commit_o.old_phys = head_entry.old_phys;
    end

    // Old tag goes back to the pool
    assign free_push_o = commit_fire && head_entry.rd_wen;
    assign free_tag_o  = head_entry.old_phys;

    // Pointers and occupancy, index wraps on its own at 16
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, commit_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry payload and done flag
    always_ff @(posedge clock) begin
        if (alloc_i) begin
            entry_q[tail_q] <= '{rd_wen:   rd_wen_i,
                                 arch:     rd_arch_i,
                                 new_phys: new_phys_i,
                                 old_phys: old_phys_i,
                                 done:     1'b0};
        end
        if (wb_i.valid) begin
            entry_q[wb_i.rob_idx].done <= 1'b1;
        end
    end

    // Completion only for slots between head and tail
    a_wb_in_flight: assert property (@(posedge clock) disable iff (reset)
        wb_i.valid |-> (rob_cnt_t'(wb_offset) < count_q))
        else $error("reorder_buffer: writeback to empty slot %0d", wb_i.rob_idx);

endmodule

`default_nettype wire

// ==== hw/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire rename_pkt_pkg::dispatch_req_t disp_i,
    output logic                               disp_ready_o,
    output rename_pkt_pkg::rename_rsp_t        rename_o,
    input  wire rename_pkt_pkg::wb_t           wb_i,
    output rename_pkt_pkg::commit_t            commit_o
);
    import rename_types_pkg::*;

    // Dispatch strobes
    logic      alloc;
    logic      rd_write;
    // Unit status
    logic      free_empty;
    logic      rob_full;
    // Rename lookups
    phys_tag_t rs1_phys;
    phys_tag_t rs2_phys;
    logic      rs1_ready;
    logic      rs2_ready;
    phys_tag_t old_phys;
    phys_tag_t head_tag;
    rob_idx_t  tail_idx;
    // Completion and retire paths
    logic      set_ready;
    phys_tag_t set_ready_tag;
    logic      free_push;
    phys_tag_t free_tag;

    // Rename result, combinational with dispatch
    always_comb begin
        rename_o.rs1_phys    = rs1_phys;
        rename_o.rs1_ready   = rs1_ready;
        rename_o.rs2_phys    = rs2_phys;
        rename_o.rs2_ready   = rs2_ready;
        rename_o.rd_new_phys = head_tag;
        rename_o.rd_old_phys = old_phys;
        rename_o.rob_idx     = tail_idx;
    end

    //////////////////////////////
    // Units
    //////////////////////////////

    dispatch_ctrl u_dispatch_ctrl (
        .clock        (clock),
        .reset        (reset),
        .disp_i       (disp_i),
        .free_empty_i (free_empty),
        .rob_full_i   (rob_full),
        .disp_ready_o (disp_ready_o),
        .alloc_o      (alloc),
        .rd_write_o   (rd_write)
    );

    map_table u_map_table (
        .clock           (clock),
        .reset           (reset),
        .rs1_i           (disp_i.rs1),
        .rs2_i           (disp_i.rs2),
        .rd_i            (disp_i.rd),
        .rd_write_i      (rd_write),
        .rd_new_phys_i   (head_tag),
        .rs1_phys_o      (rs1_phys),
        .rs2_phys_o      (rs2_phys),
        .rd_old_phys_o   (old_phys),
        .rs1_ready_o     (rs1_ready),
        .rs2_ready_o     (rs2_ready),
        .set_ready_i     (set_ready),
        .set_ready_tag_i (set_ready_tag)
    );

    // Tag popped only when a destination is renamed
    free_list u_free_list (
        .clock      (clock),
        .reset      (reset),
        .pop_i      (rd_write),
        .head_tag_o (head_tag),
        .empty_o    (free_empty),
        .push_i     (free_push),
        .push_tag_i (free_tag)
    );

    reorder_buffer u_reorder_buffer (
        .clock           (clock),
        .reset           (reset),
        .alloc_i         (alloc),
        .rd_wen_i        (rd_write),
        .rd_arch_i       (disp_i.rd),
        .new_phys_i      (head_tag),
        .old_phys_i      (old_phys),
        .tail_idx_o      (tail_idx),
        .full_o          (rob_full),
        .wb_i            (wb_i),
        .set_ready_o     (set_ready),
        .set_ready_tag_o (set_ready_tag),
        .commit_o        (commit_o),
        .free_push_o     (free_push),
        .free_tag_o      (free_tag)
    );

endmodule

`default_nettype wire

// ==== dv/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_tb;
    import rename_types_pkg::*;
    import rename_pkt_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int SEED           = 92275;

    // Model view of one in-flight instruction
    typedef struct packed {
        rob_idx_t  idx;
        logic      wen;
        arch_tag_t arch;
        phys_tag_t new_phys;
        phys_tag_t old_phys;
        logic      done;
    } rob_model_t;

    logic          clock;
    logic          reset;
    dispatch_req_t disp_i;
    logic          disp_ready_o;
    rename_rsp_t   rename_o;
    wb_t           wb_i;
    commit_t       commit_o;

    // Reference model state
    phys_tag_t  map_m [`RN_ARCH_REGS];
    logic       ready_m [`RN_PHYS_REGS];
    phys_tag_t  free_m [$];
    rob_model_t rob_m [$];
    rob_idx_t   next_idx;
    // Head seen committing in this cycle
    logic       commit_due;

    int unsigned errors;
    int unsigned checks;
    int unsigned commits;

    rename_top uut (
        .clock        (clock),
        .reset        (reset),
        .disp_i       (disp_i),
        .disp_ready_o (disp_ready_o),
        .rename_o     (rename_o),
        .wb_i         (wb_i),
        .commit_o     (commit_o)
    );

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    //////////////////////////////
    // Model and helpers
    //////////////////////////////

    function automatic void check_field(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout: %s at %0t", what, $time);
        $display("Checks %0d, errors %0d, commits %0d", checks, errors, commits);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic void reset_model();
        // Identity map with every tag ready and spare tags in order
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            map_m[i] = phys_tag_t'(i);
        end
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            ready_m[i] = 1'b1;
        end
        free_m.delete();
        for (int i = `RN_ARCH_REGS; i < `RN_PHYS_REGS; i++) begin
            free_m.push_back(phys_tag_t'(i));
        end
        rob_m.delete();
        next_idx   = '0;
        commit_due = 1'b0;
    endfunction

    function automatic arch_tag_t rand_reg(input bit nonzero);
        int unsigned low;
        low = nonzero ? 1 : 0;
        return arch_tag_t'($urandom_range(`RN_ARCH_REGS - 1, low));
    endfunction

    function automatic int find_entry(input rob_idx_t idx);
        int pos;
        pos = -1;
        foreach (rob_m[i]) begin
            if (rob_m[i].idx == idx) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // Writeback in the current cycle wakes this tag
    function automatic logic wb_wakes(input phys_tag_t tag);
        int   pos;
        logic hit;
        hit = 1'b0;
        if (wb_i.valid) begin
            pos = find_entry(wb_i.rob_idx);
            if (pos >= 0) begin
                hit = rob_m[pos].wen && (rob_m[pos].new_phys == tag);
            end
        end
        return hit;
    endfunction

    // Needs a free slot and a free tag for a real destination
    function automatic logic model_ready(input arch_tag_t rd);
        return (rob_m.size() < `RN_ROB_DEPTH) && !((free_m.size() == 0) && (rd != '0));
    endfunction

    function automatic void model_writeback(input rob_idx_t idx);
        int         pos;
        rob_model_t ent;
        pos = find_entry(idx);
        if (pos < 0) begin
            errors++;
            $display("Writeback sent to slot %0d, which holds no instruction", idx);
        end else begin
            ent        = rob_m[pos];
            ent.done   = 1'b1;
            rob_m[pos] = ent;
            if (ent.wen) begin
                ready_m[ent.new_phys] = 1'b1;
            end
        end
    endfunction

    //////////////////////////////
    // Commit monitor
    //////////////////////////////

    function automatic void check_commit();
        logic       exp_valid;
        rob_model_t ent;
        exp_valid = (rob_m.size() > 0) && rob_m[0].done;
        check_field("commit_o.valid", int'(commit_o.valid), int'(exp_valid));
        if (exp_valid && commit_o.valid) begin
            ent = rob_m[0];
            check_field("commit_o.rob_idx", int'(commit_o.rob_idx), int'(ent.idx));
            check_field("commit_o.rd_wen", int'(commit_o.rd_wen), int'(ent.wen));
            check_field("commit_o.rd_arch", int'(commit_o.rd_arch), int'(ent.arch));
            check_field("commit_o.old_phys", int'(commit_o.old_phys), int'(ent.old_phys));
            if (ent.wen) begin
                check_field("commit_o.new_phys", int'(commit_o.new_phys), int'(ent.new_phys));
            end
            commit_due = 1'b1;
            commits++;
        end
    endfunction

    // Sample mid-cycle where outputs are settled
    always @(negedge clock) begin
        if (!reset) begin
            check_commit();
        end
    end

    // Head leaves and its old tag returns to the tail
    always @(posedge clock) begin
        rob_model_t ent;
        if (commit_due) begin
            ent = rob_m.pop_front();
            if (ent.wen) begin
                free_m.push_back(ent.old_phys);
            end
            commit_due = 1'b0;
        end
    end

    //////////////////////////////
    // Drivers
    //////////////////////////////

    task automatic dispatch(input arch_tag_t rd, input arch_tag_t rs1, input arch_tag_t rs2,
                            output rename_rsp_t rsp);
        int         waited;
        logic       wen;
        rob_model_t ent;
        disp_i.valid = 1'b1;
        disp_i.rd    = rd;
        disp_i.rs1   = rs1;
        disp_i.rs2   = rs2;
        wen          = (rd != '0);
        waited       = 0;
        #1;
        forever begin
            check_field("disp_ready_o", int'(disp_ready_o), int'(model_ready(rd)));
            if (disp_ready_o) begin
                break;
            end
            if (waited == TIMEOUT_CYCLES) begin
                abort_run("dispatch was never accepted");
            end
            waited++;
            @(posedge clock);
            #1;
        end
        // Combinational rename in the transfer cycle
        rsp = rename_o;
        check_field("rename_o.rs1_phys", int'(rsp.rs1_phys), int'(map_m[rs1]));
        check_field("rename_o.rs1_ready", int'(rsp.rs1_ready),
                    int'(ready_m[map_m[rs1]] | wb_wakes(map_m[rs1])));
        check_field("rename_o.rs2_phys", int'(rsp.rs2_phys), int'(map_m[rs2]));
        check_field("rename_o.rs2_ready", int'(rsp.rs2_ready),
                    int'(ready_m[map_m[rs2]] | wb_wakes(map_m[rs2])));
        check_field("rename_o.rd_old_phys", int'(rsp.rd_old_phys), int'(map_m[rd]));
        check_field("rename_o.rob_idx", int'(rsp.rob_idx), int'(next_idx));
        if (wen) begin
            check_field("rename_o.rd_new_phys", int'(rsp.rd_new_phys), int'(free_m[0]));
        end
        @(posedge clock);
        // Model takes the transfer at this edge
        if (wb_i.valid) begin
            model_writeback(wb_i.rob_idx);
        end
        ent.idx      = next_idx;
        ent.wen      = wen;
        ent.arch     = rd;
        ent.old_phys = map_m[rd];
        ent.new_phys = '0;
        ent.done     = 1'b0;
        if (wen) begin
            ent.new_phys          = free_m.pop_front();
            map_m[rd]             = ent.new_phys;
            ready_m[ent.new_phys] = 1'b0;
        end
        rob_m.push_back(ent);
        next_idx = next_idx + 1'b1;
        #1;
        disp_i.valid = 1'b0;
        wb_i.valid   = 1'b0;
    endtask

    task automatic writeback(input rob_idx_t idx);
        wb_i.valid   = 1'b1;
        wb_i.rob_idx = idx;
        @(posedge clock);
        model_writeback(idx);
        #1;
        wb_i.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rob_m.size() != 0) begin
            if (waited == TIMEOUT_CYCLES) begin
                abort_run("reorder buffer did not drain");
            end
            waited++;
            @(posedge clock);
            #1;
        end
    endtask

    // Complete whatever is still pending in age order
    task automatic complete_all();
        rob_idx_t pending [$];
        foreach (rob_m[i]) begin
            if (!rob_m[i].done) begin
                pending.push_back(rob_m[i].idx);
            end
        end
        foreach (pending[i]) begin
            writeback(pending[i]);
        end
        wait_drain();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic reset_state();
        rename_rsp_t rsp;
        check_field("disp_ready_o", int'(disp_ready_o), 1);
        check_field("commit_o.valid", int'(commit_o.valid), 0);
        for (int i = 0; i < 3; i++) begin
            dispatch(arch_tag_t'(3*i + 1), arch_tag_t'(3*i + 2), arch_tag_t'(3*i + 3), rsp);
            // Spare tags in order and identity sources
            check_field("rename_o.rd_new_phys", int'(rsp.rd_new_phys), `RN_ARCH_REGS + i);
            check_field("rename_o.rob_idx", int'(rsp.rob_idx), i);
            check_field("rename_o.rd_old_phys", int'(rsp.rd_old_phys), 3*i + 1);
            check_field("rename_o.rs1_phys", int'(rsp.rs1_phys), 3*i + 2);
            check_field("rename_o.rs1_ready", int'(rsp.rs1_ready), 1);
        end
        complete_all();
    endtask

    task automatic dependency_renaming();
        rename_rsp_t prod;
        rename_rsp_t rsp;
        phys_tag_t   prod_tag;
        dispatch(5, 1, 2, prod);
        // Producer tag as the model handed it out
        prod_tag = map_m[5];
        // Consumer waits on the producer tag
        dispatch(6, 5, 5, rsp);
        check_field("rename_o.rs1_phys", int'(rsp.rs1_phys), int'(prod_tag));
        check_field("rename_o.rs1_ready", int'(rsp.rs1_ready), 0);
        // Producer completes in this very cycle
        wb_i.valid   = 1'b1;
        wb_i.rob_idx = prod.rob_idx;
        dispatch(8, 5, 6, rsp);
        check_field("rename_o.rs1_ready", int'(rsp.rs1_ready), 1);
        check_field("rename_o.rs2_ready", int'(rsp.rs2_ready), 0);
        // Source equal to own rd sees previous producer
        dispatch(5, 5, 0, rsp);
        check_field("rename_o.rs1_phys", int'(rsp.rs1_phys), int'(prod_tag));
        check_field("rename_o.rd_old_phys", int'(rsp.rd_old_phys), int'(prod_tag));
        complete_all();
    endtask

    task automatic in_order_commit();
        rename_rsp_t rsp;
        rob_idx_t    idx_q [$];
        for (int i = 0; i < 4; i++) begin
            dispatch(rand_reg(1), rand_reg(0), rand_reg(0), rsp);
            idx_q.push_back(rsp.rob_idx);
        end
        // Youngest finishes first
        for (int i = 3; i >= 0; i--) begin
            writeback(idx_q[i]);
        end
        wait_drain();
    endtask

    task automatic free_list_recycle();
        rename_rsp_t first;
        rename_rsp_t rsp;
        arch_tag_t   first_rd;
        phys_tag_t   first_old;
        arch_tag_t   rd;
        arch_tag_t   rs1;
        arch_tag_t   rs2;
        first_rd  = rand_reg(1);
        // Oldest instruction's old tag comes back at its commit
        first_old = map_m[first_rd];
        dispatch(first_rd, rand_reg(0), rand_reg(0), first);
        for (int i = 1; i < `RN_PHYS_REGS - `RN_ARCH_REGS; i++) begin
            dispatch(rand_reg(1), rand_reg(0), rand_reg(0), rsp);
        end
        // No spare tags left so a renaming request stalls
        rd  = rand_reg(1);
        rs1 = rand_reg(0);
        rs2 = rand_reg(0);
        disp_i.valid = 1'b1;
        disp_i.rd    = rd;
        disp_i.rs1   = rs1;
        disp_i.rs2   = rs2;
        #1;
        check_field("disp_ready_o", int'(disp_ready_o), 0);
        writeback(first.rob_idx);
        // Held request gets the recycled tag
        dispatch(rd, rs1, rs2, rsp);
        check_field("rename_o.rd_new_phys", int'(rsp.rd_new_phys), int'(first_old));
        complete_all();
    endtask

    task automatic rob_full_stall();
        rename_rsp_t rsp;
        phys_tag_t   next_tag;
        arch_tag_t   rs1;
        arch_tag_t   rs2;
        next_tag = free_m[0];
        for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
            dispatch('0, rand_reg(0), rand_reg(0), rsp);
        end
        // Full buffer stalls even an x0 writer
        rs1 = rand_reg(0);
        rs2 = rand_reg(0);
        disp_i.valid = 1'b1;
        disp_i.rd    = '0;
        disp_i.rs1   = rs1;
        disp_i.rs2   = rs2;
        #1;
        check_field("disp_ready_o", int'(disp_ready_o), 0);
        writeback(rob_m[0].idx);
        dispatch('0, rs1, rs2, rsp);
        complete_all();
        // x0 commits gave nothing back
        dispatch(rand_reg(1), rand_reg(0), rand_reg(0), rsp);
        check_field("rename_o.rd_new_phys", int'(rsp.rd_new_phys), int'(next_tag));
        complete_all();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(SEED));
        errors   = 0;
        checks   = 0;
        commits  = 0;
        disp_i   = '0;
        wb_i     = '0;
        reset    = 1'b1;
        reset_model();
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        reset_state();
        dependency_renaming();
        in_order_commit();
        free_list_recycle();
        rob_full_stall();

        $display("Checks %0d, errors %0d, commits %0d", checks, errors, commits);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/rename_types_pkg.sv
hw/rename_pkt_pkg.sv
hw/dispatch_ctrl.sv
hw/map_table.sv
hw/free_list.sv
hw/reorder_buffer.sv
hw/rename_top.sv
dv/rename_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
